// File: hw/lpddr5_cache_pkg.sv
`default_nettype none

package lpddr5_cache_pkg;

  // ==================================================
  // Cache geometry.
  // ==================================================

  localparam int line_w  = 256;             // Data bits per line.
  localparam int index_w = 7;               // 128 lines.
  localparam int addr_w  = 27;              // Line address, not byte address.
  localparam int tag_w   = addr_w - index_w;

  typedef logic [line_w-1:0] line_t;

  // Low bits select the line, upper bits are kept in the tag RAM.
  typedef struct packed {
    logic [tag_w-1:0]   tag;
    logic [index_w-1:0] index;
  } line_addr_t;

  // ==================================================
  // Storage and transfer words.
  // ==================================================

  // Tag RAM word.
  typedef struct packed {
    logic             valid;
    logic             dirty;
    logic [tag_w-1:0] tag;
  } tag_entry_t;

  // Whole-line request, also the queue word.
  typedef struct packed {
    logic       is_write;
    line_addr_t addr;
    line_t      data;
  } cache_req_t;

  // Read response.
  typedef struct packed {
    line_addr_t addr;
    line_t      data;
  } cache_rsp_t;

  // Memory command. Reads carry zero data.
  typedef struct packed {
    logic       is_write;
    line_addr_t addr;
    line_t      data;
  } mem_cmd_t;

endpackage

`default_nettype wire

// File: hw/lpddr5_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lpddr5_data_ram (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 rd_en,
  input  logic [lpddr5_cache_pkg::index_w-1:0] rd_index,
  output lpddr5_cache_pkg::line_t              rd_data,
  input  logic                                 wr_en,
  input  logic [lpddr5_cache_pkg::index_w-1:0] wr_index,
  input  lpddr5_cache_pkg::line_t              wr_data
);
  import lpddr5_cache_pkg::*;

  line_t              lines [1 << index_w];
  logic [index_w-1:0] rd_index_q;

  assign rd_data = lines[rd_index_q];  // Valid the cycle after rd_en.

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_index_q <= '0;
    end else if (rd_en) begin
      rd_index_q <= rd_index;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      lines[wr_index] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/lpddr5_tag_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lpddr5_tag_ram (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 rd_en,
  input  logic [lpddr5_cache_pkg::index_w-1:0] rd_index,
  output lpddr5_cache_pkg::tag_entry_t         rd_data,
  input  logic                                 wr_en,
  input  logic [lpddr5_cache_pkg::index_w-1:0] wr_index,
  input  lpddr5_cache_pkg::tag_entry_t         wr_data
);
  import lpddr5_cache_pkg::*;

  // Entries are invalidated by the controller's sweep after reset.
  tag_entry_t         entries [1 << index_w];
  logic [index_w-1:0] rd_index_q;

  assign rd_data = entries[rd_index_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_index_q <= '0;
    end else if (rd_en) begin
      rd_index_q <= rd_index;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[wr_index] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/lpddr5_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

module lpddr5_req_queue #(
  parameter int depth_log2 = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         push,
  input  lpddr5_cache_pkg::cache_req_t push_data,
  input  logic                         pop,
  output lpddr5_cache_pkg::cache_req_t head,
  output logic                         empty,
  output logic                         stall
);
  import lpddr5_cache_pkg::*;

  localparam int depth = 1 << depth_log2;
  localparam logic [depth_log2:0] stall_level = (depth_log2 + 1)'(depth - 1);

  cache_req_t            store [depth];
  logic [depth_log2-1:0] wr_ptr;
  logic [depth_log2-1:0] rd_ptr;
  logic [depth_log2:0]   count;  // One bit wider to hold a full queue.

  assign head  = store[rd_ptr];
  assign empty = (count == '0);

  always_ff @(posedge clk) begin
    if (push) begin
      store[wr_ptr] <= push_data;
    end
  end

  // ==================================================
  // Pointers, occupancy and stall.
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      stall  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth.
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle, or push and pop together.
      endcase

      // Lags the count by one cycle, so one late push still fits.
      stall <= (count >= stall_level);
    end
  end

endmodule

`default_nettype wire

// File: hw/lpddr5_cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lpddr5_cache_ctrl (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 q_empty,
  input  lpddr5_cache_pkg::cache_req_t         q_head,
  output logic                                 q_pop,
  output logic                                 tag_rd_en,
  output logic [lpddr5_cache_pkg::index_w-1:0] tag_rd_index,
  input  lpddr5_cache_pkg::tag_entry_t         tag_rd_data,
  output logic                                 tag_wr_en,
  output logic [lpddr5_cache_pkg::index_w-1:0] tag_wr_index,
  output lpddr5_cache_pkg::tag_entry_t         tag_wr_data,
  output logic                                 dat_rd_en,
  output logic [lpddr5_cache_pkg::index_w-1:0] dat_rd_index,
  input  lpddr5_cache_pkg::line_t              dat_rd_data,
  output logic                                 dat_wr_en,
  output logic [lpddr5_cache_pkg::index_w-1:0] dat_wr_index,
  output lpddr5_cache_pkg::line_t              dat_wr_data,
  output logic                                 mem_cmd_en,
  output lpddr5_cache_pkg::mem_cmd_t           mem_cmd,
  input  logic                                 mem_rd_en,
  input  lpddr5_cache_pkg::line_t              mem_rd_data,
  output logic                                 rsp_en,
  output lpddr5_cache_pkg::cache_rsp_t         rsp
);
  import lpddr5_cache_pkg::*;

  typedef enum logic [2:0] {
    s_clear,
    s_idle,
    s_lookup,
    s_compare,
    s_wb,
    s_fill,
    s_finish
  } state_t;

  state_t             state;
  logic [index_w-1:0] clr_index;
  cache_req_t         req_q;         // Request being served.
  line_t              line_q;        // Hit line or fill data.
  logic               hit_q;
  logic               hit;
  logic               dirty_victim;
  logic               install;
  line_addr_t         victim_addr;

  assign hit          = tag_rd_data.valid && (tag_rd_data.tag == req_q.addr.tag);
  assign dirty_victim = tag_rd_data.valid && tag_rd_data.dirty;
  assign install      = (state == s_finish) && (req_q.is_write || !hit_q);

  assign victim_addr.tag   = tag_rd_data.tag;
  assign victim_addr.index = req_q.addr.index;

  // ==================================================
  // Queue, RAM and response strobes.
  // ==================================================

  assign q_pop = (state == s_idle) && !q_empty;

  // Tag and data are always read together.
  assign tag_rd_en    = (state == s_lookup);
  assign dat_rd_en    = (state == s_lookup);
  assign tag_rd_index = req_q.addr.index;
  assign dat_rd_index = req_q.addr.index;

  assign tag_wr_en    = (state == s_clear) || install;
  assign tag_wr_index = (state == s_clear) ? clr_index : req_q.addr.index;

  always_comb begin
    tag_wr_data = '0;  // Invalid entry for the sweep.
    if (state != s_clear) begin
      tag_wr_data.valid = 1'b1;
      tag_wr_data.dirty = req_q.is_write;  // Fills go in clean.
      tag_wr_data.tag   = req_q.addr.tag;
    end
  end

  assign dat_wr_en    = install;
  assign dat_wr_index = req_q.addr.index;
  assign dat_wr_data  = req_q.is_write ? req_q.data : line_q;

  assign rsp_en    = (state == s_finish) && !req_q.is_write;
  assign rsp.addr  = req_q.addr;
  assign rsp.data  = line_q;

  // ==================================================
  // State machine.
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= s_clear;
      clr_index  <= '0;
      mem_cmd_en <= 1'b0;
    end else begin
      mem_cmd_en <= 1'b0;
      case (state)
        s_clear: begin
          clr_index <= clr_index + 1'b1;
          if (&clr_index) begin
            state <= s_idle;  // Last entry written this cycle.
          end
        end
        s_idle: begin
          if (!q_empty) begin
            state <= s_lookup;
          end
        end
        s_lookup: state <= s_compare;
        s_compare: begin
          if (hit) begin
            state <= s_finish;
          end else if (dirty_victim) begin
            mem_cmd_en <= 1'b1;  // Victim goes out first.
            state      <= s_wb;
          end else if (!req_q.is_write) begin
            mem_cmd_en <= 1'b1;
            state      <= s_fill;
          end else begin
            state <= s_finish;   // Write miss needs no fill.
          end
        end
        s_wb: begin
          if (req_q.is_write) begin
            state <= s_finish;
          end else begin
            mem_cmd_en <= 1'b1;
            state      <= s_fill;
          end
        end
        s_fill: begin
          if (mem_rd_en) begin
            state <= s_finish;
          end
        end
        s_finish: state <= s_idle;
        default:  state <= s_idle;
      endcase
    end
  end

  // Payload registers.
  always_ff @(posedge clk) begin
    if (q_pop) begin
      req_q <= q_head;
    end

    if (state == s_compare) begin
      line_q           <= dat_rd_data;
      hit_q            <= hit;
      mem_cmd.is_write <= dirty_victim;
      mem_cmd.addr     <= dirty_victim ? victim_addr : req_q.addr;
      mem_cmd.data     <= dirty_victim ? dat_rd_data : '0;
    end

    if (state == s_wb) begin
      mem_cmd.is_write <= 1'b0;  // Read for the new line.
      mem_cmd.addr     <= req_q.addr;
      mem_cmd.data     <= '0;
    end

    if ((state == s_fill) && mem_rd_en) begin
      line_q <= mem_rd_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/lpddr5_cache.sv
`timescale 1ns/1ps
`default_nettype none

module lpddr5_cache #(
  parameter int queue_depth_log2 = 4
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         req_en,
  input  lpddr5_cache_pkg::cache_req_t req,
  output logic                         stall,
  output logic                         rsp_en,
  output lpddr5_cache_pkg::cache_rsp_t rsp,
  output logic                         mem_cmd_en,
  output lpddr5_cache_pkg::mem_cmd_t   mem_cmd,
  input  logic                         mem_rd_en,
  input  lpddr5_cache_pkg::line_t      mem_rd_data
);
  import lpddr5_cache_pkg::*;

  cache_req_t         q_head;
  logic               q_empty;
  logic               q_pop;

  logic               tag_rd_en;
  logic [index_w-1:0] tag_rd_index;
  tag_entry_t         tag_rd_data;
  logic               tag_wr_en;
  logic [index_w-1:0] tag_wr_index;
  tag_entry_t         tag_wr_data;

  logic               dat_rd_en;
  logic [index_w-1:0] dat_rd_index;
  line_t              dat_rd_data;
  logic               dat_wr_en;
  logic [index_w-1:0] dat_wr_index;
  line_t              dat_wr_data;

  // ==================================================
  // Request queue.
  // ==================================================

  lpddr5_req_queue #(
    .depth_log2 (queue_depth_log2)
  ) u_queue (
    .clk       (clk),
    .rst       (rst),
    .push      (req_en),
    .push_data (req),
    .pop       (q_pop),
    .head      (q_head),
    .empty     (q_empty),
    .stall     (stall)
  );

  // ==================================================
  // Controller and line storage.
  // ==================================================

  lpddr5_cache_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .q_empty      (q_empty),
    .q_head       (q_head),
    .q_pop        (q_pop),
    .tag_rd_en    (tag_rd_en),
    .tag_rd_index (tag_rd_index),
    .tag_rd_data  (tag_rd_data),
    .tag_wr_en    (tag_wr_en),
    .tag_wr_index (tag_wr_index),
    .tag_wr_data  (tag_wr_data),
    .dat_rd_en    (dat_rd_en),
    .dat_rd_index (dat_rd_index),
    .dat_rd_data  (dat_rd_data),
    .dat_wr_en    (dat_wr_en),
    .dat_wr_index (dat_wr_index),
    .dat_wr_data  (dat_wr_data),
    .mem_cmd_en   (mem_cmd_en),
    .mem_cmd      (mem_cmd),
    .mem_rd_en    (mem_rd_en),
    .mem_rd_data  (mem_rd_data),
    .rsp_en       (rsp_en),
    .rsp          (rsp)
  );

  lpddr5_tag_ram u_tag_ram (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (tag_rd_en),
    .rd_index (tag_rd_index),
    .rd_data  (tag_rd_data),
    .wr_en    (tag_wr_en),
    .wr_index (tag_wr_index),
    .wr_data  (tag_wr_data)
  );

  lpddr5_data_ram u_data_ram (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (dat_rd_en),
    .rd_index (dat_rd_index),
    .rd_data  (dat_rd_data),
    .wr_en    (dat_wr_en),
    .wr_index (dat_wr_index),
    .wr_data  (dat_wr_data)
  );

endmodule

`default_nettype wire

// File: tb/lpddr5_tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module lpddr5_tb_mem (
  input  logic                       clk,
  input  logic                       mem_cmd_en,
  input  lpddr5_cache_pkg::mem_cmd_t mem_cmd,
  output logic                       mem_rd_en,
  output lpddr5_cache_pkg::line_t    mem_rd_data
);
  import lpddr5_cache_pkg::*;

  line_t              written [logic [addr_w-1:0]];  // Lines stored by write commands.
  logic [31:0]        lfsr;
  logic               pending;
  int                 delay;
  logic [addr_w-1:0]  rd_addr;

  // Unwritten lines hold their own address, repeated.
  function automatic line_t line_init(input logic [addr_w-1:0] a);
    return {8{5'b0, a}};
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Read latency of 2 to 9 cycles, one LFSR step per bit.
  task automatic draw_latency(output int cycles);
    cycles = 2;
    for (int i = 0; i < 3; i++) begin
      lfsr   = lfsr_next(lfsr);
      cycles = cycles + (int'(lfsr[0]) << i);
    end
  endtask

  initial begin
    mem_rd_en   = 1'b0;
    mem_rd_data = '0;
    pending     = 1'b0;
    delay       = 0;
    rd_addr     = '0;
    lfsr        = 32'hd80e900b;
    forever begin
      @(negedge clk);
      if (mem_cmd_en) begin
        if (mem_cmd.is_write) begin
          written[mem_cmd.addr] = mem_cmd.data;
        end else begin
          pending = 1'b1;
          rd_addr = mem_cmd.addr;
          draw_latency(delay);
        end
      end
      @(posedge clk);
      #1;
      mem_rd_en = 1'b0;
      if (pending) begin
        delay = delay - 1;
        if (delay == 0) begin
          mem_rd_en   = 1'b1;  // One-cycle data pulse.
          mem_rd_data = written.exists(rd_addr) ? written[rd_addr] : line_init(rd_addr);
          pending     = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/lpddr5_cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lpddr5_cache_tb;
  import lpddr5_cache_pkg::*;

  localparam int stall_limit = 400;   // Cycles a push may wait on stall.
  localparam int drain_limit = 2000;  // Cycles to wait for expected traffic.

  logic       clk;
  logic       rst;
  logic       req_en;
  cache_req_t req;
  logic       stall;
  logic       rsp_en;
  cache_rsp_t rsp;
  logic       mem_cmd_en;
  mem_cmd_t   mem_cmd;
  logic       mem_rd_en;
  line_t      mem_rd_data;

  // ==================================================
  // Reference model state.
  // ==================================================

  line_t             shadow [logic [addr_w-1:0]];  // Last data written per line.
  logic              model_valid [1 << index_w];
  logic              model_dirty [1 << index_w];
  logic [tag_w-1:0]  model_tag [1 << index_w];
  cache_rsp_t        exp_rsp [$];
  mem_cmd_t          exp_cmd [$];
  line_addr_t        burst_addrs [$];
  logic [31:0]       lfsr;
  logic              stall_seen;

  lpddr5_cache #(
    .queue_depth_log2 (4)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .req_en      (req_en),
    .req         (req),
    .stall       (stall),
    .rsp_en      (rsp_en),
    .rsp         (rsp),
    .mem_cmd_en  (mem_cmd_en),
    .mem_cmd     (mem_cmd),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_data (mem_rd_data)
  );

  lpddr5_tb_mem mem (
    .clk         (clk),
    .mem_cmd_en  (mem_cmd_en),
    .mem_cmd     (mem_cmd),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_data (mem_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic line_t line_init(input line_addr_t a);
    return {8{5'b0, a}};  // Address repeated across the line.
  endfunction

  function automatic line_t latest_line(input line_addr_t a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return line_init(a);
  endfunction

  function automatic line_addr_t make_addr(input logic [tag_w-1:0]   tag,
                                           input logic [index_w-1:0] index);
    line_addr_t a;
    a.tag   = tag;
    a.index = index;
    return a;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic check_rsp(input cache_rsp_t exp, input cache_rsp_t act);
    if (act !== exp) begin
      stop_run($sformatf("Fail at %0t: rsp expected %h got %h", $time, exp, act));
    end
  endtask

  task automatic check_mem_cmd(input mem_cmd_t exp, input mem_cmd_t act);
    if (act !== exp) begin
      stop_run($sformatf("Fail at %0t: mem_cmd expected %h got %h", $time, exp, act));
    end
  endtask

  // Direct-mapped model, applied in request order.
  task automatic apply_model(input cache_req_t r);
    logic [index_w-1:0] idx;
    logic               hit;
    line_addr_t         victim;
    mem_cmd_t           cmd;
    cache_rsp_t         rsp_exp;
    idx = r.addr.index;
    hit = model_valid[idx] && (model_tag[idx] == r.addr.tag);
    if (!hit && model_valid[idx] && model_dirty[idx]) begin
      victim       = make_addr(model_tag[idx], idx);
      cmd.is_write = 1'b1;
      cmd.addr     = victim;
      cmd.data     = latest_line(victim);
      exp_cmd.push_back(cmd);
    end
    if (!hit && !r.is_write) begin
      cmd.is_write = 1'b0;
      cmd.addr     = r.addr;
      cmd.data     = '0;
      exp_cmd.push_back(cmd);
    end
    if (r.is_write) begin
      shadow[r.addr] = r.data;
    end else begin
      rsp_exp.addr = r.addr;
      rsp_exp.data = latest_line(r.addr);
      exp_rsp.push_back(rsp_exp);
    end
    if (r.is_write || !hit) begin
      model_valid[idx] = 1'b1;
      model_tag[idx]   = r.addr.tag;
      model_dirty[idx] = r.is_write;  // Fills go in clean.
    end
  endtask

  // ==================================================
  // Stimulus and waits.
  // ==================================================

  task automatic push_req(input logic is_write, input line_addr_t addr, input line_t data);
    cache_req_t r;
    int         waited;
    r.is_write = is_write;
    r.addr     = addr;
    r.data     = data;
    waited     = 0;
    @(posedge clk);
    #1;
    while (stall) begin
      req_en = 1'b0;
      waited++;
      if (waited > stall_limit) begin
        stop_run("stall stayed high and the request queue never drained");
      end
      @(posedge clk);
      #1;
    end
    req_en = 1'b1;
    req    = r;
    apply_model(r);
  endtask

  task automatic end_push();
    @(posedge clk);
    #1;
    req_en = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_rsp.size() != 0) || (exp_cmd.size() != 0)) begin
      @(posedge clk);
      cycles++;
      if (cycles > drain_limit) begin
        stop_run("expected responses or memory commands never arrived");
      end
    end
  endtask

  // Compares every response and memory command in order.
  initial begin
    stall_seen = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (stall) stall_seen = 1'b1;
        if (rsp_en) begin
          if (exp_rsp.size() == 0) stop_run("a response came with none expected");
          else check_rsp(exp_rsp.pop_front(), rsp);
        end
        if (mem_cmd_en) begin
          if (exp_cmd.size() == 0) stop_run("a memory command came with none expected");
          else check_mem_cmd(exp_cmd.pop_front(), mem_cmd);
        end
      end
    end
  end

  initial begin
    logic [31:0]        bits;
    logic               is_wr;
    logic [tag_w-1:0]   tag;
    logic [index_w-1:0] idx;
    line_addr_t         a;
    line_addr_t         b;
    rst    = 1'b1;
    req_en = 1'b0;
    req    = '0;
    lfsr   = 32'hd80e900b;
    foreach (model_valid[i]) begin
      model_valid[i] = 1'b0;
      model_dirty[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Quiet through the tag sweep.
    repeat (140) begin
      @(posedge clk);
      #1;
      if (stall || rsp_en || mem_cmd_en) begin
        stop_run("stall, rsp_en or mem_cmd_en went high before any request");
      end
    end

    a = make_addr(20'h00012, 7'h05);  // Fill, then hit.
    push_req(1'b0, a, '0);
    push_req(1'b0, a, '0);
    end_push();
    wait_drain();

    a = make_addr(20'h00034, 7'h09);
    push_req(1'b1, a, {8{32'hc0de0001}});
    push_req(1'b0, a, '0);
    end_push();
    wait_drain();

    // Dirty victim, then its data back from memory.
    a = make_addr(20'h00056, 7'h11);
    b = make_addr(20'h00078, 7'h11);
    push_req(1'b1, a, {8{32'h5a5a0002}});
    push_req(1'b0, b, '0);
    push_req(1'b0, a, '0);
    end_push();
    wait_drain();

    a = make_addr(20'h0009a, 7'h20);
    b = make_addr(20'h000bc, 7'h20);
    push_req(1'b0, a, '0);
    push_req(1'b0, b, '0);  // Clean eviction.
    end_push();
    wait_drain();

    // ==================================================
    // Random burst on four indices.
    // ==================================================

    for (int i = 0; i < 24; i++) begin
      take_bits(1, bits);
      is_wr = bits[0];
      take_bits(3, bits);
      tag = tag_w'(bits[2:0]);
      take_bits(2, bits);
      idx = 7'h40 + 7'(bits[1:0]);
      a = make_addr(tag, idx);
      take_bits(32, bits);
      if (is_wr) burst_addrs.push_back(a);
      push_req(is_wr, a, {8{bits}});
    end
    foreach (burst_addrs[i]) begin
      push_req(1'b0, burst_addrs[i], '0);
    end
    end_push();
    if (!stall_seen) begin
      stop_run("stall never rose during the burst");
    end
    wait_drain();

    repeat (20) @(posedge clk);  // Trailing writes settle.
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
hw/lpddr5_cache_pkg.sv
hw/lpddr5_data_ram.sv
hw/lpddr5_tag_ram.sv
hw/lpddr5_req_queue.sv
hw/lpddr5_cache_ctrl.sv
hw/lpddr5_cache.sv
tb/lpddr5_tb_mem.sv
tb/lpddr5_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
TOP       ?= lpddr5_cache_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
